// File: all.f
+incdir+logic
logic/cdac_data_pkg.sv
logic/cdac_ctrl_pkg.sv
logic/sclk_divider.sv
logic/al_capture.sv
logic/cdac_load_fsm.sv
logic/cdac_shifter.sv
logic/cdac_top.sv
dv/cdac_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the threshold DAC testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f all.f --top-module cdac_tb --Mdir obj_dir -o Vcdac_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vcdac_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "NO ERRORS"; then
	exit 0
fi

echo "pass message not found"
exit 1

// File: dv/cdac_tb.sv
`include "cdac_cfg.svh"

module cdac_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 2000;  // CLK40 cycles for any single wait

	logic                     CLK40;
	logic                     RST;
	logic                     capture;
	cdac_data_pkg::thr_word_t thr_value;
	logic                     clr_al_done;
	logic                     dac_sclk;
	logic                     shck_ena;
	logic                     sdata;
	logic                     dac_enb;
	logic                     cdac_done;

	int          errors;
	int          checks;
	int          tests;
	int          start_errs;  // Error count when the running test began
	logic [15:0] lfsr;

	cdac_top DUT (
		.CLK40       (CLK40),
		.RST         (RST),
		.capture     (capture),
		.thr_value   (thr_value),
		.clr_al_done (clr_al_done),
		.dac_sclk    (dac_sclk),
		.shck_ena    (shck_ena),
		.sdata       (sdata),
		.dac_enb     (dac_enb),
		.cdac_done   (cdac_done)
	);

	initial begin
		CLK40 = 1'b0;
		forever #5 CLK40 = ~CLK40;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	// Three zero pad bits, threshold MSB first, one trailing zero
	function automatic logic [`CDAC_FRAME_W-1:0] padded_frame(
			input logic [`CDAC_THR_W-1:0] thr);
		return {{`CDAC_PAD_W{1'b0}}, thr, 1'b0};
	endfunction

	task automatic draw_threshold(output cdac_data_pkg::thr_word_t thr);
		thr = '0;
		for (int i = 0; i < `CDAC_THR_W; i++) begin
			lfsr = lfsr_next(lfsr);
			thr  = {thr[`CDAC_THR_W-2:0], lfsr[0]};  // One step per bit
		end
	endtask

	task automatic check_bit(input string test, input string what,
			input logic exp, input logic act);
		checks++;
		assert (act === exp) else begin
			$display("mismatch %s %s: expected %b, actual %b", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input string test, input string what, input int exp, input int act);
		checks++;
		assert (act == exp) else begin
			$display("mismatch %s %s: expected 0x%0h, actual 0x%0h", test, what, exp, act);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == start_errs)
			$display("test %s passed", name);
		else
			$display("test %s failed with %0d errors", name, errors - start_errs);
	endtask

	task automatic pulse_capture(input cdac_data_pkg::thr_word_t thr);
		@(posedge CLK40);
		#1;
		capture   = 1'b1;
		thr_value = thr;
		@(posedge CLK40);
		#1;
		capture = 1'b0;
	endtask

	// CLK40 cycles until dac_sclk next changes
	task automatic sclk_gap(input string test, output int n);
		logic prev;
		bit   seen;
		prev = dac_sclk;
		seen = 1'b0;
		n    = 0;
		for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
			@(negedge CLK40);
			n++;
			if (dac_sclk !== prev)
				seen = 1'b1;
		end
		checks++;
		assert (seen) else begin
			$display("%s: dac_sclk stopped toggling", test);
			errors++;
		end
	endtask

	// Captures thr and collects the frame until cdac_done rises.
	// With late set, a second capture goes in once shifting has begun.
	task automatic send_frame(input string test, input cdac_data_pkg::thr_word_t thr,
			input bit late, input cdac_data_pkg::thr_word_t thr_late,
			output logic [`CDAC_FRAME_W-1:0] frame, output int periods);
		bit   seen_done;
		bit   enb_drop;
		bit   late_sent;
		logic sclk_prev;
		logic shck_prev;
		seen_done = 1'b0;
		enb_drop  = 1'b0;
		late_sent = 1'b0;
		frame     = '0;
		periods   = 0;
		pulse_capture(thr);
		sclk_prev = dac_sclk;
		shck_prev = shck_ena;
		for (int i = 0; i < WAIT_LIMIT && !seen_done; i++) begin
			@(negedge CLK40);
			if (cdac_done) begin
				seen_done = 1'b1;
			end
			else begin
				if (!dac_enb)
					enb_drop = 1'b1;
				if (dac_sclk && !sclk_prev && shck_ena) begin
					frame = {frame[`CDAC_FRAME_W-2:0], sdata};  // DAC samples on rise
					periods++;
				end
				if (late && shck_ena && !shck_prev && !late_sent) begin
					pulse_capture(thr_late);
					late_sent = 1'b1;
				end
				sclk_prev = dac_sclk;
				shck_prev = shck_ena;
			end
		end
		checks++;
		assert (seen_done) else begin
			$display("%s: timed out waiting for cdac_done", test);
			errors++;
		end
		check_bit(test, "dac_enb during load", 1'b1, !enb_drop);
		if (seen_done)
			check_bit(test, "dac_enb after done", 1'b0, dac_enb);
	endtask

	task automatic clear_done(input string test);
		@(posedge CLK40);
		#1;
		clr_al_done = 1'b1;
		@(posedge CLK40);
		#1;
		clr_al_done = 1'b0;
		@(negedge CLK40);
		check_bit(test, "cdac_done after clear", 1'b0, cdac_done);
		repeat (100) @(posedge CLK40);  // Idle gap before the next capture
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic test_reset_state();
		int n;
		start_errs = errors;
		@(negedge CLK40);
		check_bit("reset_state", "shck_ena", 1'b0, shck_ena);
		check_bit("reset_state", "sdata", 1'b0, sdata);
		check_bit("reset_state", "dac_enb", 1'b0, dac_enb);
		check_bit("reset_state", "cdac_done", 1'b0, cdac_done);
		sclk_gap("reset_state", n);  // Align to a toggle
		sclk_gap("reset_state", n);
		check_word("reset_state", "sclk high half", `CDAC_SCLK_HALF, n);
		sclk_gap("reset_state", n);
		check_word("reset_state", "sclk low half", `CDAC_SCLK_HALF, n);
		end_test("reset_state");
	endtask

	task automatic test_single_load();
		logic [`CDAC_FRAME_W-1:0] got;
		int                       periods;
		start_errs = errors;
		send_frame("single_load", 12'hA5C, 1'b0, '0, got, periods);
		check_word("single_load", "frame", int'(padded_frame(12'hA5C)), int'(got));
		check_word("single_load", "shck_ena periods", `CDAC_FRAME_W, periods);
		clear_done("single_load");
		end_test("single_load");
	endtask

	task automatic test_done_flag();
		logic [`CDAC_FRAME_W-1:0] got;
		int                       periods;
		bit                       held;
		start_errs = errors;
		held       = 1'b1;
		send_frame("done_flag", 12'h3C1, 1'b0, '0, got, periods);
		for (int i = 0; i < 200; i++) begin
			@(negedge CLK40);
			if (!cdac_done || dac_enb)
				held = 1'b0;
		end
		checks++;
		assert (held) else begin
			$display("done_flag: cdac_done dropped or dac_enb came back while idle");
			errors++;
		end
		clear_done("done_flag");
		end_test("done_flag");
	endtask

	task automatic test_capture_during_load();
		logic [`CDAC_FRAME_W-1:0] got;
		int                       periods;
		start_errs = errors;
		send_frame("capture_during_load", 12'h3F0, 1'b1, 12'h0C7, got, periods);
		check_word("capture_during_load", "frame in flight",
			int'(padded_frame(12'h3F0)), int'(got));
		clear_done("capture_during_load");
		send_frame("capture_during_load", 12'h0C7, 1'b0, '0, got, periods);
		check_word("capture_during_load", "next frame", int'(padded_frame(12'h0C7)), int'(got));
		clear_done("capture_during_load");
		end_test("capture_during_load");
	endtask

	task automatic test_random_sweep();
		logic [`CDAC_FRAME_W-1:0] got;
		int                       periods;
		cdac_data_pkg::thr_word_t thr;
		string                    name;
		start_errs = errors;
		for (int k = 0; k < 8; k++) begin
			name = $sformatf("random_sweep[%0d]", k);
			draw_threshold(thr);
			send_frame(name, thr, 1'b0, '0, got, periods);
			check_word(name, "frame", int'(padded_frame(thr)), int'(got));
			check_word(name, "shck_ena periods", `CDAC_FRAME_W, periods);
			clear_done(name);
		end
		end_test("random_sweep");
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		RST         = 1'b1;
		capture     = 1'b0;
		thr_value   = '0;
		clr_al_done = 1'b0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		start_errs  = 0;
		lfsr        = 16'd40246;
		repeat (8) @(posedge CLK40);
		#1;
		RST = 1'b0;

		test_reset_state();
		test_single_load();
		test_done_flag();
		test_capture_during_load();
		test_random_sweep();

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: logic/cdac_top.sv
module cdac_top (
	input  logic                      CLK40,
	input  logic                      RST,
	input  logic                      capture,
	input  cdac_data_pkg::thr_word_t  thr_value,
	input  logic                      clr_al_done,
	output logic                      dac_sclk,
	output logic                      shck_ena,
	output logic                      sdata,
	output logic                      dac_enb,
	output logic                      cdac_done
);

	logic                     sclk;      // 1 MHz serial clock
	logic                     load;
	logic                     shft_ena;
	logic                     set_done;
	cdac_data_pkg::thr_word_t thr_hold;

	//////////////////////////////
	// Clock and 40 MHz side
	//////////////////////////////

	sclk_divider u_sclk_div (
		.CLK40 (CLK40),
		.RST   (RST),
		.sclk  (sclk)
	);

	al_capture u_capture (
		.CLK40       (CLK40),
		.RST         (RST),
		.capture     (capture),
		.thr_value   (thr_value),
		.clr_al_done (clr_al_done),
		.set_done    (set_done),
		.load        (load),
		.thr_hold    (thr_hold),
		.done        (cdac_done)
	);

	//////////////////////////////
	// 1 MHz side
	//////////////////////////////

	cdac_load_fsm u_load_fsm (
		.sclk     (sclk),
		.RST      (RST),
		.start    (load),
		.shft_ena (shft_ena),
		.set_done (set_done)
	);

	cdac_shifter u_shifter (
		.sclk     (sclk),
		.RST      (RST),
		.load     (load),
		.thr_hold (thr_hold),
		.shft_ena (shft_ena),
		.sdata    (sdata)
	);

	assign dac_sclk = sclk;
	assign shck_ena = shft_ena;  // DAC shift clock enable
	assign dac_enb  = load;

endmodule

// File: logic/cdac_shifter.sv
`include "cdac_cfg.svh"

module cdac_shifter (
	input  logic                      sclk,
	input  logic                      RST,
	input  logic                      load,
	input  cdac_data_pkg::thr_word_t  thr_hold,
	input  logic                      shft_ena,
	output logic                      sdata
);

	localparam int TAIL_W = `CDAC_FRAME_W - `CDAC_PAD_W - `CDAC_THR_W;

	logic                       load_q;   // Load seen on the last falling edge
	logic                       le_load;  // Leading edge of load
	cdac_data_pkg::cdac_frame_t frame;
	cdac_data_pkg::cdac_frame_t frame_init;

	//////////////////////////////
	// Frame build and shift
	//////////////////////////////

	// Pad, threshold MSB first, trailing zero
	assign frame_init = {{`CDAC_PAD_W{1'b0}}, thr_hold, {TAIL_W{1'b0}}};

	always_ff @(negedge sclk or posedge RST) begin
		if (RST)
			load_q <= 1'b0;
		else
			load_q <= load;
	end

	assign le_load = load & ~load_q;

	always_ff @(negedge sclk or posedge RST) begin
		if (RST) begin
			frame <= '0;
		end
		else if (le_load) begin
			frame <= frame_init;
		end
		else if (shft_ena) begin
			frame <= {frame[`CDAC_FRAME_W-2:0], 1'b0};
		end
	end

	assign sdata = frame[`CDAC_FRAME_W-1];  // Stable across the rising edge

	// A new frame never lands on top of one still shifting
	a_no_reload: assert property (@(negedge sclk) disable iff (RST)
		!(le_load && shft_ena));

	// Frame is fully shifted out once shifting ends
	a_frame_empty: assert property (@(negedge sclk) disable iff (RST)
		$fell(shft_ena) |-> (frame == '0));

endmodule

// File: logic/cdac_load_fsm.sv
`include "cdac_cfg.svh"

module cdac_load_fsm (
	input  logic sclk,
	input  logic RST,
	input  logic start,
	output logic shft_ena,
	output logic set_done
);

	localparam cdac_data_pkg::bit_cnt_t LAST_BIT =
		cdac_data_pkg::bit_cnt_t'(`CDAC_FRAME_W - 1);

	cdac_ctrl_pkg::load_state_t state;
	cdac_ctrl_pkg::load_state_t state_nx;
	cdac_data_pkg::bit_cnt_t    bit_cnt;  // Shift periods done so far

	//////////////////////////////
	// Next state
	//////////////////////////////

	always_comb begin
		state_nx = state;
		case (state)
			cdac_ctrl_pkg::ST_IDLE: begin
				if (start)
					state_nx = cdac_ctrl_pkg::ST_SHIFT;
			end
			cdac_ctrl_pkg::ST_SHIFT: begin
				if (bit_cnt == LAST_BIT)
					state_nx = cdac_ctrl_pkg::ST_FINISH;
			end
			cdac_ctrl_pkg::ST_FINISH: begin
				// Load normally gone by now so go straight back to idle
				if (start)
					state_nx = cdac_ctrl_pkg::ST_RELEASE;
				else
					state_nx = cdac_ctrl_pkg::ST_IDLE;
			end
			cdac_ctrl_pkg::ST_RELEASE: begin
				if (!start)
					state_nx = cdac_ctrl_pkg::ST_IDLE;
			end
			default: state_nx = cdac_ctrl_pkg::ST_IDLE;
		endcase
	end

	//////////////////////////////
	// State, counter, outputs
	//////////////////////////////

	always_ff @(negedge sclk or posedge RST) begin
		if (RST) begin
			state    <= cdac_ctrl_pkg::ST_IDLE;
			bit_cnt  <= '0;
			shft_ena <= 1'b0;
			set_done <= 1'b0;
		end
		else begin
			state    <= state_nx;
			shft_ena <= (state_nx == cdac_ctrl_pkg::ST_SHIFT);
			set_done <= (state_nx == cdac_ctrl_pkg::ST_FINISH);

			if (state == cdac_ctrl_pkg::ST_SHIFT)
				bit_cnt <= bit_cnt + 1'b1;
			else
				bit_cnt <= '0;  // Ready for the next frame
		end
	end

	// Shifting and completion never overlap
	a_excl: assert property (@(negedge sclk) disable iff (RST)
		!(shft_ena && set_done));

	// Exactly one frame of shift periods, then the done pulse
	a_frame_len: assert property (@(negedge sclk) disable iff (RST)
		$rose(shft_ena) |-> shft_ena [*`CDAC_FRAME_W] ##1 set_done);

endmodule

// File: logic/al_capture.sv
module al_capture (
	input  logic                      CLK40,
	input  logic                      RST,
	input  logic                      capture,
	input  cdac_data_pkg::thr_word_t  thr_value,
	input  logic                      clr_al_done,
	input  logic                      set_done,
	output logic                      load,
	output cdac_data_pkg::thr_word_t  thr_hold,
	output logic                      done
);

	logic load_req;     // Load level before hold-off
	logic set_meta;     // First synchronizer stage
	logic set_sync;     // Second synchronizer stage
	logic set_sync_q;   // Edge detect delay
	logic set_rise;

	//////////////////////////////
	// Threshold hold register
	//////////////////////////////

	always_ff @(posedge CLK40) begin
		if (capture)
			thr_hold <= thr_value;  // Also taken while a frame runs
	end

	//////////////////////////////
	// set_done from the sclk side
	//////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			set_meta   <= 1'b0;
			set_sync   <= 1'b0;
			set_sync_q <= 1'b0;
		end
		else begin
			set_meta   <= set_done;
			set_sync   <= set_meta;
			set_sync_q <= set_sync;
		end
	end

	assign set_rise = set_sync & ~set_sync_q;

	//////////////////////////////
	// Load level and done flag
	//////////////////////////////

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			load_req <= 1'b0;
			done     <= 1'b0;
		end
		else begin
			load_req <= done ? 1'b0 : (capture ? 1'b1 : load_req);
			done     <= clr_al_done ? 1'b0 : (set_rise ? 1'b1 : done);  // Clear wins
		end
	end

	// Held low while set_done is still high on the sclk side so that the FSM
	// and the shifter always sample a low load between two frames
	assign load = load_req & ~set_sync_q;

	// Done only follows a synchronized set_done edge
	a_done_src: assert property (@(posedge CLK40) disable iff (RST)
		$rose(done) |-> $past(set_rise));

endmodule

// File: logic/sclk_divider.sv
`include "cdac_cfg.svh"

module sclk_divider (
	input  logic CLK40,
	input  logic RST,
	output logic sclk
);

	localparam int CNT_W = $clog2(`CDAC_SCLK_HALF);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`CDAC_SCLK_HALF - 1);

	logic [CNT_W-1:0] half_cnt;

	// Toggle once per half period and start low
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			half_cnt <= '0;
			sclk     <= 1'b0;
		end
		else if (half_cnt == CNT_LAST) begin
			half_cnt <= '0;
			sclk     <= ~sclk;
		end
		else begin
			half_cnt <= half_cnt + 1'b1;
		end
	end

	// Counter wraps at the last count
	a_cnt_range: assert property (@(posedge CLK40) disable iff (RST)
		half_cnt <= CNT_LAST);

endmodule

// File: logic/cdac_ctrl_pkg.sv
package cdac_ctrl_pkg;

	//////////////////////////////
	// Load sequencing
	//////////////////////////////

	// Threshold load FSM, runs on the falling serial clock edge
	typedef enum logic [1:0] {
		ST_IDLE    = 2'd0,  // Waiting for a load level
		ST_SHIFT   = 2'd1,  // Frame going out
		ST_FINISH  = 2'd2,  // One period of set_done
		ST_RELEASE = 2'd3   // Load still high, hold off re-arming
	} load_state_t;

endpackage

// File: logic/cdac_data_pkg.sv
`include "cdac_cfg.svh"

package cdac_data_pkg;

	//////////////////////////////
	// Data path vectors
	//////////////////////////////

	// Threshold word as written by software
	typedef logic [`CDAC_THR_W-1:0] thr_word_t;

	// Padded serial word, bit FRAME_W-1 goes out first
	typedef logic [`CDAC_FRAME_W-1:0] cdac_frame_t;

	// Counts shift periods, wide enough to hold FRAME_W
	typedef logic [$clog2(`CDAC_FRAME_W + 1)-1:0] bit_cnt_t;

endpackage

// File: logic/cdac_cfg.svh
`ifndef CDAC_CFG_SVH
`define CDAC_CFG_SVH

//////////////////////////////
// Threshold DAC frame layout
//////////////////////////////

`define CDAC_THR_W 12      // Comparator threshold bits
`define CDAC_FRAME_W 16    // Full serial word
`define CDAC_PAD_W 3       // Leading zero bits ahead of the threshold

//////////////////////////////
// Serial clock
//////////////////////////////

// CLK40 cycles per half period, 40 MHz / (2 * 20) = 1 MHz
`define CDAC_SCLK_HALF 20

`endif
